/* verilog/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_XLEN      32
`define CPU_NREGS     32
`define CPU_RESET_PC  32'h1c000000

// major opcode of the 3R format in inst[31:15]
`define CPU_OP3R_ADD   17'h00020
`define CPU_OP3R_SUB   17'h00022
`define CPU_OP3R_SLT   17'h00024
`define CPU_OP3R_SLTU  17'h00025
`define CPU_OP3R_AND   17'h00029
`define CPU_OP3R_OR    17'h0002a
`define CPU_OP3R_XOR   17'h0002b

// addi.w in inst[31:22], lu12i.w in inst[31:25]
`define CPU_OP_ADDI   10'h00a
`define CPU_OP_LU12I  7'h0a

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_t;

    // decode -> execute
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     a;
        word_t     b;
        reg_addr_t rd;
        logic      we;
    } ex_payload_t;

    // execute -> regfile, forwarding and debug port
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     result;
    } wb_payload_t;

endpackage

/* verilog/regfile.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module regfile
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  reg_addr_t   raddr1,
    input  reg_addr_t   raddr2,
    output word_t       rdata1,
    output word_t       rdata2,
    input  logic        wb_valid,
    input  wb_payload_t wb
);

    word_t regs [`CPU_NREGS];

    // r0 is never written and stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  inst_sram_en,
    output word_t inst_sram_addr,
    input  word_t inst_sram_rdata,
    output logic  id_valid,
    output word_t id_pc,
    output word_t id_inst
);

    word_t pc;
    word_t req_pc;
    logic  req_valid;

    // requests start at the first edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_sram_en <= 1'b0;
            pc           <= `CPU_RESET_PC;
            req_valid    <= 1'b0;
            id_valid     <= 1'b0;
        end else begin
            inst_sram_en <= 1'b1;
            if (inst_sram_en) begin
                pc <= pc + word_t'(4);
            end
            req_valid <= inst_sram_en;
            id_valid  <= req_valid;
        end
    end

    assign inst_sram_addr = pc;

    // rdata belongs to the address of the previous cycle
    always_ff @(posedge clk) begin
        req_pc  <= pc;
        id_pc   <= req_pc;
        id_inst <= inst_sram_rdata;
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        id_valid,
    input  word_t       id_pc,
    input  word_t       id_inst,
    output reg_addr_t   raddr1,
    output reg_addr_t   raddr2,
    input  word_t       rdata1,
    input  word_t       rdata2,
    input  logic        ex_fwd_valid,
    input  wb_payload_t ex_fwd,
    input  logic        wb_valid,
    input  wb_payload_t wb,
    output logic        ex_valid,
    output ex_payload_t ex
);

    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    word_t       imm_si12;
    word_t       imm_lu12i;
    logic        is_addi;
    logic        is_lu12i;
    logic        op3r_hit;
    alu_op_t     op3r;
    word_t       src_j;
    word_t       src_k;
    ex_payload_t ex_next;

    // newest producer wins, then regfile
    function automatic word_t fwd_sel(
        input reg_addr_t   src,
        input word_t       rf_val,
        input logic        exv,
        input wb_payload_t exp,
        input logic        wbv,
        input wb_payload_t wbp
    );
        if (src != '0 && exv && exp.we && exp.rd == src) begin
            return exp.result;
        end
        if (src != '0 && wbv && wbp.we && wbp.rd == src) begin
            return wbp.result;
        end
        return rf_val;
    endfunction

    assign rd = id_inst[4:0];
    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    assign imm_si12  = {{(`CPU_XLEN-12){id_inst[21]}}, id_inst[21:10]};
    assign imm_lu12i = {id_inst[24:5], 12'b0};

    assign is_addi  = (id_inst[31:22] == `CPU_OP_ADDI);
    assign is_lu12i = (id_inst[31:25] == `CPU_OP_LU12I);

    always_comb begin
        op3r_hit = 1'b1;
        op3r     = ALU_ADD;
        case (id_inst[31:15])
            `CPU_OP3R_ADD:  op3r = ALU_ADD;
            `CPU_OP3R_SUB:  op3r = ALU_SUB;
            `CPU_OP3R_SLT:  op3r = ALU_SLT;
            `CPU_OP3R_SLTU: op3r = ALU_SLTU;
            `CPU_OP3R_AND:  op3r = ALU_AND;
            `CPU_OP3R_OR:   op3r = ALU_OR;
            `CPU_OP3R_XOR:  op3r = ALU_XOR;
            default:        op3r_hit = 1'b0;
        endcase
    end

    assign raddr1 = rj;
    assign raddr2 = rk;

    assign src_j = fwd_sel(rj, rdata1, ex_fwd_valid, ex_fwd, wb_valid, wb);
    assign src_k = fwd_sel(rk, rdata2, ex_fwd_valid, ex_fwd, wb_valid, wb);

    // unknown encodings keep we low and retire as bubbles
    always_comb begin
        ex_next.pc     = id_pc;
        ex_next.rd     = rd;
        ex_next.alu_op = op3r;
        ex_next.a      = src_j;
        ex_next.b      = src_k;
        ex_next.we     = op3r_hit;
        if (is_addi) begin
            ex_next.alu_op = ALU_ADD;
            ex_next.b      = imm_si12;
            ex_next.we     = 1'b1;
        end else if (is_lu12i) begin
            ex_next.alu_op = ALU_LUI;
            ex_next.b      = imm_lu12i;
            ex_next.we     = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex <= ex_next;
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_valid,
    input  ex_payload_t ex,
    output logic        ex_fwd_valid,
    output wb_payload_t ex_fwd,
    output logic        wb_valid,
    output wb_payload_t wb
);

    word_t alu_result;
    logic  lt_signed;
    logic  lt_unsigned;

    assign lt_signed   = $signed(ex.a) < $signed(ex.b);
    assign lt_unsigned = ex.a < ex.b;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  alu_result = ex.a + ex.b;
            ALU_SUB:  alu_result = ex.a - ex.b;
            ALU_SLT:  alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            ALU_AND:  alu_result = ex.a & ex.b;
            ALU_OR:   alu_result = ex.a | ex.b;
            ALU_XOR:  alu_result = ex.a ^ ex.b;
            // immediate already shifted in decode
            ALU_LUI:  alu_result = ex.b;
        endcase
    end

    // unregistered result back to decode
    assign ex_fwd_valid = ex_valid;

    always_comb begin
        ex_fwd.pc     = ex.pc;
        ex_fwd.rd     = ex.rd;
        ex_fwd.we     = ex.we;
        ex_fwd.result = alu_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb <= ex_fwd;
    end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output logic      inst_sram_en,
    output word_t     inst_sram_addr,
    input  word_t     inst_sram_rdata,
    output word_t     debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    logic        id_valid;
    word_t       id_pc;
    word_t       id_inst;
    reg_addr_t   rf_raddr1;
    reg_addr_t   rf_raddr2;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    logic        ex_valid;
    ex_payload_t ex;
    logic        ex_fwd_valid;
    wb_payload_t ex_fwd;
    logic        wb_valid;
    wb_payload_t wb;

    fetch_stage i_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_inst         (id_inst)
    );

    decode_stage i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .raddr1       (rf_raddr1),
        .raddr2       (rf_raddr2),
        .rdata1       (rf_rdata1),
        .rdata2       (rf_rdata2),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd       (ex_fwd),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .ex_valid     (ex_valid),
        .ex           (ex)
    );

    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1   (rf_raddr1),
        .raddr2   (rf_raddr2),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    execute_stage i_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd       (ex_fwd),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

    // debug port shows the retiring instruction
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_we    = {4{wb_valid && wb.we && (wb.rd != '0)}};
    assign debug_wb_rf_wnum  = wb.rd;
    assign debug_wb_rf_wdata = wb.result;

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/1ns
`include "cpu_config.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int ROM_WORDS  = 512;
    localparam int N_RANDOM   = 200;
    localparam int N_SECTIONS = 5;

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t rd;
        word_t     result;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t  rom [ROM_WORDS];
    word_t  ref_regs [`CPU_NREGS];
    int     sec_end [N_SECTIONS];
    string  sec_name [N_SECTIONS];
    int     n_prog;
    int     errors;
    int     fetch_errors;
    int     errors_before;
    integer seed;
    logic   pend_en;
    word_t  pend_addr;
    logic   fetch_seen;
    word_t  last_addr;

    cpu_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_pc(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s pc %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_wnum(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s wnum %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_wdata(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s wdata %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_we(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s we %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic word_t enc_3r(input logic [16:0] op, input int rd, input int rj,
                                     input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_addi(input int rd, input int rj, input int imm);
        return {`CPU_OP_ADDI, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_lu12i(input int rd, input int imm);
        return {`CPU_OP_LU12I, imm[19:0], rd[4:0]};
    endfunction

    function automatic logic [16:0] op3r_code(input int k);
        case (k)
            0:       return `CPU_OP3R_ADD;
            1:       return `CPU_OP3R_SUB;
            2:       return `CPU_OP3R_SLT;
            3:       return `CPU_OP3R_SLTU;
            4:       return `CPU_OP3R_AND;
            5:       return `CPU_OP3R_OR;
            default: return `CPU_OP3R_XOR;
        endcase
    endfunction

    // one instruction on the reference register array
    function automatic expect_t ref_step(input word_t pc, input word_t inst);
        expect_t e;
        word_t   a;
        word_t   b;
        logic    known;
        a        = ref_regs[inst[9:5]];
        b        = ref_regs[inst[14:10]];
        known    = 1'b1;
        e.pc     = pc;
        e.rd     = inst[4:0];
        e.result = '0;
        if (inst[31:22] == `CPU_OP_ADDI) begin
            e.result = a + word_t'($signed(inst[21:10]));
        end else if (inst[31:25] == `CPU_OP_LU12I) begin
            e.result = word_t'(inst[24:5]) << 12;
        end else begin
            case (inst[31:15])
                `CPU_OP3R_ADD:  e.result = a + b;
                `CPU_OP3R_SUB:  e.result = a - b;
                `CPU_OP3R_SLT:  e.result = ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
                `CPU_OP3R_SLTU: e.result = (a < b) ? 32'd1 : 32'd0;
                `CPU_OP3R_AND:  e.result = a & b;
                `CPU_OP3R_OR:   e.result = a | b;
                `CPU_OP3R_XOR:  e.result = a ^ b;
                default:        known = 1'b0;
            endcase
        end
        e.we = known && (e.rd != 5'd0);
        if (e.we) begin
            ref_regs[e.rd] = e.result;
        end
        return e;
    endfunction

    function automatic word_t rom_read(input word_t addr);
        word_t offset;
        offset = (addr - `CPU_RESET_PC) >> 2;
        if (offset < word_t'(ROM_WORDS)) begin
            return rom[int'(offset)];
        end
        return '0;
    endfunction

    task automatic emit(input word_t inst);
        rom[n_prog] = inst;
        n_prog++;
    endtask

    task automatic close_section(input int s, input string name);
        sec_end[s]  = n_prog - 1;
        sec_name[s] = name;
    endtask

    task automatic build_program();
        word_t rnd;
        word_t rnd2;
        int    kind;
        // the first write marks the first retirement
        emit(enc_addi(1, 0, 'h123));
        emit(enc_addi(2, 0, -5));
        emit(enc_lu12i(3, 'h80000));
        emit(enc_addi(4, 0, 7));
        emit(enc_addi(5, 4, 2047));
        emit(enc_addi(6, 4, -2048));
        emit(enc_3r(`CPU_OP3R_ADD, 7, 1, 2));
        emit(enc_3r(`CPU_OP3R_SUB, 8, 1, 2));
        emit(enc_3r(`CPU_OP3R_SLT, 9, 2, 1));
        emit(enc_3r(`CPU_OP3R_SLTU, 10, 2, 1));
        emit(enc_3r(`CPU_OP3R_SLT, 11, 3, 4));
        emit(enc_3r(`CPU_OP3R_SLTU, 12, 3, 4));
        emit(enc_3r(`CPU_OP3R_AND, 13, 1, 2));
        emit(enc_3r(`CPU_OP3R_OR, 14, 1, 3));
        emit(enc_3r(`CPU_OP3R_XOR, 15, 2, 3));
        close_section(0, "alu");
        // chains at distance 1, 2 and 3
        for (int k = 0; k < 4; k++) begin
            emit(enc_addi(16, 16, 3));
        end
        emit(enc_3r(`CPU_OP3R_ADD, 17, 16, 16));
        for (int k = 0; k < 3; k++) begin
            emit(enc_addi(18, 18, 5));
            emit(enc_3r(`CPU_OP3R_SUB, 19, 19, 18));
        end
        for (int k = 0; k < 3; k++) begin
            emit(enc_addi(20, 20, -9));
            emit(enc_3r(`CPU_OP3R_XOR, 21, 21, 16));
            emit(enc_3r(`CPU_OP3R_ADD, 22, 20, 22));
        end
        close_section(1, "forwarding");
        emit(enc_addi(0, 1, 99));
        emit(enc_3r(`CPU_OP3R_ADD, 0, 1, 1));
        emit(enc_3r(`CPU_OP3R_ADD, 23, 0, 1));
        emit(enc_lu12i(0, 'hfffff));
        emit(enc_3r(`CPU_OP3R_OR, 24, 0, 0));
        emit(enc_addi(25, 0, 1));
        close_section(2, "register zero");
        emit(enc_addi(26, 0, 11));
        emit(32'h0000_001f);
        emit(enc_3r(`CPU_OP3R_ADD, 27, 26, 26));
        emit(enc_3r(17'h00031, 26, 1, 2));
        emit(32'hffff_ffff);
        emit(enc_3r(`CPU_OP3R_ADD, 28, 26, 31));
        emit(enc_3r(`CPU_OP3R_SUB, 29, 27, 26));
        close_section(3, "unknown encoding");
        // registers 0 to 15 only, to keep hazards frequent
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            kind = int'(rnd % 32'd20);
            if (kind < 7) begin
                emit(enc_3r(op3r_code(kind), int'(rnd[8:5]), int'(rnd[12:9]),
                            int'(rnd[16:13])));
            end else if (kind < 15) begin
                emit(enc_addi(int'(rnd[8:5]), int'(rnd[12:9]), int'(rnd2[11:0])));
            end else if (kind < 19) begin
                emit(enc_lu12i(int'(rnd[8:5]), int'(rnd2[19:0])));
            end else begin
                emit(enc_3r(17'h00031, int'(rnd[8:5]), int'(rnd[12:9]), 0));
            end
        end
        close_section(4, "random");
    endtask

    task automatic report_test(input string name, input int n_err);
        if (n_err == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, n_err);
        end
    endtask

    // sram model and fetch sequence monitor
    always @(negedge clk) begin
        if (pend_en) begin
            inst_sram_rdata = rom_read(pend_addr);
        end
        pend_en   = inst_sram_en;
        pend_addr = inst_sram_addr;
        if (!rst_n) begin
            if (inst_sram_en !== 1'b0 || debug_wb_rf_we !== 4'b0000) begin
                errors++;
                fetch_errors++;
                $display("FAILED at %0t ns: sram enable or register write during reset",
                         $time);
            end
        end else if (inst_sram_en === 1'b1) begin
            errors_before = errors;
            check_pc(inst_sram_addr, fetch_seen ? last_addr + 32'd4 : `CPU_RESET_PC,
                     "fetch address");
            if (errors != errors_before) begin
                fetch_errors++;
            end
            fetch_seen = 1'b1;
            last_addr  = inst_sram_addr;
        end
    end

    task automatic run_compare();
        int      wait_cycles;
        int      sec;
        int      sec_base;
        expect_t e;
        logic    we_got;
        string   what;
        wait_cycles = 0;
        while (inst_sram_en !== 1'b1 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (inst_sram_en !== 1'b1) begin
            errors++;
            $display("no instruction fetch within 20 cycles after reset release");
            return;
        end
        wait_cycles = 0;
        while (debug_wb_rf_we !== 4'b1111 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (debug_wb_rf_we !== 4'b1111) begin
            errors++;
            $display("first instruction did not retire within 20 cycles of its fetch");
            return;
        end
        if (wait_cycles != 4) begin
            errors++;
            $display("FAILED at %0t ns: first retirement %0d cycles after fetch, expected 4",
                     $time, wait_cycles);
        end
        sec      = 0;
        sec_base = errors;
        for (int i = 0; i < n_prog; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            what = $sformatf("instruction %0d", i);
            e    = ref_step(`CPU_RESET_PC + word_t'(i * 4), rom[i]);
            check_pc(debug_wb_pc, e.pc, what);
            we_got = (debug_wb_rf_we == 4'b1111) ? 1'b1 :
                     ((debug_wb_rf_we == 4'b0000) ? 1'b0 : 1'bx);
            check_we(we_got, e.we, what);
            if (e.we) begin
                check_wnum(debug_wb_rf_wnum, e.rd, what);
                check_wdata(debug_wb_rf_wdata, e.result, what);
            end
            if (i == sec_end[sec]) begin
                report_test(sec_name[sec], errors - sec_base);
                sec++;
                sec_base = errors;
            end
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        pend_en         = 1'b0;
        pend_addr       = '0;
        fetch_seen      = 1'b0;
        last_addr       = '0;
        errors          = 0;
        fetch_errors    = 0;
        errors_before   = 0;
        seed            = 16;
        n_prog          = 0;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            ref_regs[i] = '0;
        end
        // unused words decode as unknown encodings
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = ~(`CPU_RESET_PC + word_t'(i * 4));
        end
        build_program();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        run_compare();
        report_test("fetch", fetch_errors);
        $display("tests %0d, instructions %0d, errors %0d", N_SECTIONS + 1, n_prog, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu_top.sv
tests/tb_cpu.sv

/* Makefile */
TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
